// ==== source/acq_cfg.svh ====
//////////////////////////////////////////////////
// Build-time sizes for the ADC acquisition front end
// Included by the RTL, the package and the testbench
//////////////////////////////////////////////////
`ifndef ACQ_CFG_SVH
`define ACQ_CFG_SVH

// Sample memory address width, giving a 4096-word buffer
`define ACQ_ADDR_W 12
// One ADC word holds two 16-bit samples and a header word is the same width
`define ACQ_WORD_W 32
// Header FIFO depth in words, enough for three complete events
`define ACQ_HDR_DEPTH 16
// Number of header words written for every event
`define ACQ_HDR_WORDS 5

`endif

// ==== source/acq_pkg.sv ====
//////////////////////////////////////////////////
// Shared types for the acquisition front end
// Imported by the control, the header FIFO and the testbench
//////////////////////////////////////////////////
`default_nettype none
`include "acq_cfg.svh"

package acq_pkg;

	// Bit positions in the one-hot state vector of the acquisition FSM
	typedef enum logic [3:0] {
		IDLE, INIT, WAIT_TRIG, TRIGGERED, WAIT_POST_TRIG,
		HDR_TRIG_NUM1, HDR_TRIG_NUM2, HDR_BUF_SIZE1, HDR_BUF_SIZE2,
		HDR_CHAN_NUM1, HDR_CHAN_NUM2, HDR_POST_TRIG1, HDR_POST_TRIG2,
		HDR_START_ADR1, HDR_START_ADR2, DONE
	} acq_state_e;

	// Field routed into the header word register
	typedef enum logic [2:0] {
		SEL_TRIG_NUM, SEL_BUF_SIZE, SEL_CHAN_NUM, SEL_POST_TRIG, SEL_START_ADR
	} hdr_sel_e;

	// The start-address word keeps its upper bits at zero
	typedef struct packed {
		logic [`ACQ_WORD_W-`ACQ_ADDR_W-1:0] reserved;
		logic [`ACQ_ADDR_W-1:0]             start_adr;
	} hdr_adr_t;

	// A header word is either a plain value or a start-address word
	typedef union packed {
		logic [`ACQ_WORD_W-1:0] raw;
		hdr_adr_t               adr;
	} hdr_word_u;

endpackage

`default_nettype wire

// ==== source/acq_ctrl_if.sv ====
//////////////////////////////////////////////////
// Control strobes from the acquisition FSM to the datapath blocks
// Status and the write address travel back the other way
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps
`include "acq_cfg.svh"

interface acq_ctrl_if;
	import acq_pkg::*;

	// Strobes and levels decoded from the FSM state
	logic                   init;
	logic                   run;
	logic                   post_count;
	logic                   latch_start;
	hdr_sel_e               hdr_sel;
	logic                   hdr_wr;
	logic                   trig_adv;
	logic                   trig_load;

	// Results from the address generator
	logic                   post_done;
	logic [`ACQ_ADDR_W-1:0] start_adr;
	logic [`ACQ_ADDR_W-1:0] wr_addr;
	logic                   wr_en;

	modport ctrl (output init, run, post_count, latch_start, hdr_sel, hdr_wr,
		trig_adv, trig_load, input post_done);
	modport addr (input init, run, post_count, latch_start,
		output post_done, start_adr, wr_addr, wr_en);
	modport hdr (input hdr_sel, hdr_wr, trig_adv, trig_load, start_adr);

endinterface

`default_nettype wire

// ==== source/acq_control.sv ====
//////////////////////////////////////////////////
// Input synchronizers and the one-hot acquisition FSM
// Drives every strobe on the control interface
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module acq_control (
	input  wire      clk,
	input  wire      rst_sync1,
	input  wire      arm,
	input  wire      trig,
	input  wire      trig_num_we,
	output logic     done,
	acq_ctrl_if.ctrl bus
);
	import acq_pkg::*;

	// Two flops per asynchronous input
	logic arm_s1;
	logic arm_s2;
	logic trig_s1;
	logic trig_s2;
	logic trig_num_we_s1;
	logic trig_num_we_s2;

	// One bit per state, indexed by acq_state_e
	logic [DONE:IDLE] state;
	logic [DONE:IDLE] next;

	//////////////////////////////////////////////////
	// Synchronizers
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_sync1) begin
			arm_s1         <= 1'b0;
			arm_s2         <= 1'b0;
			trig_s1        <= 1'b0;
			trig_s2        <= 1'b0;
			trig_num_we_s1 <= 1'b0;
			trig_num_we_s2 <= 1'b0;
		end else begin
			arm_s1         <= arm;
			arm_s2         <= arm_s1;
			trig_s1        <= trig;
			trig_s2        <= trig_s1;
			trig_num_we_s1 <= trig_num_we;
			trig_num_we_s2 <= trig_num_we_s1;
		end
	end

	//////////////////////////////////////////////////
	// State register and next-state logic
	//////////////////////////////////////////////////
	// Withdrawing arm sends the FSM back to IDLE from any state
	always_ff @(posedge clk) begin
		if (rst_sync1 || !arm_s2) begin
			state       <= '0;
			state[IDLE] <= 1'b1;
		end else begin
			state <= next;
		end
	end

	// Only the two wait states branch, the header states walk straight through
	always_comb begin
		next = '0;
		case (1'b1)
			state[IDLE]:           next[INIT] = 1'b1;
			state[INIT]:           next[WAIT_TRIG] = 1'b1;
			state[WAIT_TRIG]:      next[trig_s2 ? TRIGGERED : WAIT_TRIG] = 1'b1;
			state[TRIGGERED]:      next[WAIT_POST_TRIG] = 1'b1;
			state[WAIT_POST_TRIG]: next[bus.post_done ? HDR_TRIG_NUM1 : WAIT_POST_TRIG] = 1'b1;
			state[HDR_TRIG_NUM1]:  next[HDR_TRIG_NUM2] = 1'b1;
			state[HDR_TRIG_NUM2]:  next[HDR_BUF_SIZE1] = 1'b1;
			state[HDR_BUF_SIZE1]:  next[HDR_BUF_SIZE2] = 1'b1;
			state[HDR_BUF_SIZE2]:  next[HDR_CHAN_NUM1] = 1'b1;
			state[HDR_CHAN_NUM1]:  next[HDR_CHAN_NUM2] = 1'b1;
			state[HDR_CHAN_NUM2]:  next[HDR_POST_TRIG1] = 1'b1;
			state[HDR_POST_TRIG1]: next[HDR_POST_TRIG2] = 1'b1;
			state[HDR_POST_TRIG2]: next[HDR_START_ADR1] = 1'b1;
			state[HDR_START_ADR1]: next[HDR_START_ADR2] = 1'b1;
			state[HDR_START_ADR2]: next[DONE] = 1'b1;
			// DONE holds until arm drops
			default:               next[DONE] = 1'b1;
		endcase
	end

	//////////////////////////////////////////////////
	// Strobe decode
	//////////////////////////////////////////////////
	assign bus.init        = state[INIT];
	assign bus.run         = state[WAIT_TRIG] | state[TRIGGERED] | state[WAIT_POST_TRIG];
	assign bus.post_count  = state[TRIGGERED] | state[WAIT_POST_TRIG];
	assign bus.latch_start = state[HDR_TRIG_NUM1];
	// The trigger number advances only after its own header word is in the FIFO
	assign bus.trig_adv    = state[HDR_BUF_SIZE1];
	assign bus.trig_load   = trig_num_we_s2;
	// Second state of each pair pushes the word registered in the first
	assign bus.hdr_wr      = state[HDR_TRIG_NUM2] | state[HDR_BUF_SIZE2] | state[HDR_CHAN_NUM2]
		| state[HDR_POST_TRIG2] | state[HDR_START_ADR2];
	assign done            = state[DONE];

	// Both states of a pair select the same field
	always_comb begin
		if (state[HDR_BUF_SIZE1] || state[HDR_BUF_SIZE2])
			bus.hdr_sel = SEL_BUF_SIZE;
		else if (state[HDR_CHAN_NUM1] || state[HDR_CHAN_NUM2])
			bus.hdr_sel = SEL_CHAN_NUM;
		else if (state[HDR_POST_TRIG1] || state[HDR_POST_TRIG2])
			bus.hdr_sel = SEL_POST_TRIG;
		else if (state[HDR_START_ADR1] || state[HDR_START_ADR2])
			bus.hdr_sel = SEL_START_ADR;
		else
			bus.hdr_sel = SEL_TRIG_NUM;
	end

	// Exactly one state bit is set on every cycle out of reset
	a_state_onehot: assert property (@(posedge clk) disable iff (rst_sync1) $onehot(state))
		else $error("acquisition FSM state vector is not one-hot");

endmodule

`default_nettype wire

// ==== source/acq_addr_gen.sv ====
//////////////////////////////////////////////////
// Circular write address, post-trigger countdown and start address
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps
`include "acq_cfg.svh"

module acq_addr_gen (
	input wire                   clk,
	input wire                   rst_sync1,
	input wire [`ACQ_ADDR_W-1:0] post_trig_size,
	input wire [`ACQ_ADDR_W-1:0] buffer_size,
	acq_ctrl_if.addr             bus
);

	// Words still to record after the trigger
	logic [`ACQ_ADDR_W-1:0] post_cnt;

	//////////////////////////////////////////////////
	// Write address and enable
	//////////////////////////////////////////////////
	// The counter wraps at the memory size, which makes the buffer circular
	always_ff @(posedge clk) begin
		if (rst_sync1 || bus.init)
			bus.wr_addr <= '0;
		else if (bus.run)
			bus.wr_addr <= bus.wr_addr + 1'b1;
	end

	// Write enable trails run by one cycle
	always_ff @(posedge clk) begin
		if (rst_sync1)
			bus.wr_en <= 1'b0;
		else
			bus.wr_en <= bus.run;
	end

	//////////////////////////////////////////////////
	// Post-trigger counter and start address
	//////////////////////////////////////////////////
	// Loaded at the start of each acquisition, then held at zero once drained
	always_ff @(posedge clk) begin
		if (rst_sync1)
			post_cnt <= '0;
		else if (bus.init)
			post_cnt <= post_trig_size;
		else if (bus.post_count && post_cnt != '0)
			post_cnt <= post_cnt - 1'b1;
	end

	assign bus.post_done = (post_cnt == '0);

	// Start of the readout window, counted back from the final address mod 4096
	always_ff @(posedge clk) begin
		if (bus.latch_start)
			bus.start_adr <= bus.wr_addr - buffer_size;
	end

	// Outside of init and run the address must hold for the header and readout
	a_addr_hold: assert property (@(posedge clk) disable iff (rst_sync1)
		!bus.run && !bus.init |=> $stable(bus.wr_addr))
		else $error("write address moved outside an acquisition");

endmodule

`default_nettype wire

// ==== source/acq_header_fifo.sv ====
//////////////////////////////////////////////////
// Trigger number, header word register and header FIFO
// Read from outside through hdr_rd and hdr_rd_data
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps
`include "acq_cfg.svh"

module acq_header_fifo (
	input  wire                    clk,
	input  wire                    rst_sync1,
	input  wire [`ACQ_WORD_W-1:0]  buffer_size,
	input  wire [`ACQ_WORD_W-1:0]  channel_num,
	input  wire [`ACQ_WORD_W-1:0]  post_trig_size,
	input  wire [`ACQ_WORD_W-1:0]  initial_trig_num,
	input  wire                    hdr_rd,
	output logic [`ACQ_WORD_W-1:0] current_trig_num,
	output logic [`ACQ_WORD_W-1:0] hdr_rd_data,
	output logic                   hdr_empty,
	output logic                   hdr_overflow,
	acq_ctrl_if.hdr                bus
);
	import acq_pkg::*;

	localparam int PTR_W = $clog2(`ACQ_HDR_DEPTH);

	hdr_word_u              hdr_next;
	hdr_word_u              hdr_q;
	logic [`ACQ_WORD_W-1:0] fifo_mem [`ACQ_HDR_DEPTH];
	logic [PTR_W-1:0]       rd_ptr;
	logic [PTR_W-1:0]       wr_idx;
	logic [PTR_W:0]         count;
	logic                   full;
	logic                   push;
	logic                   pop;

	// Register load wins over the per-event increment
	always_ff @(posedge clk) begin
		if (rst_sync1)
			current_trig_num <= '0;
		else if (bus.trig_load)
			current_trig_num <= initial_trig_num;
		else if (bus.trig_adv)
			current_trig_num <= current_trig_num + 1'b1;
	end

	//////////////////////////////////////////////////
	// Header word selection
	//////////////////////////////////////////////////
	always_comb begin
		hdr_next.raw = current_trig_num;
		case (bus.hdr_sel)
			SEL_BUF_SIZE:  hdr_next.raw = buffer_size;
			SEL_CHAN_NUM:  hdr_next.raw = channel_num;
			SEL_POST_TRIG: hdr_next.raw = post_trig_size;
			SEL_START_ADR: begin
				hdr_next.adr.reserved  = '0;
				hdr_next.adr.start_adr = bus.start_adr;
			end
			default:       hdr_next.raw = current_trig_num;
		endcase
	end

	always_ff @(posedge clk) begin
		hdr_q <= hdr_next;
	end

	//////////////////////////////////////////////////
	// FIFO storage
	//////////////////////////////////////////////////
	// The write slot sits count entries past the head, wrapping with the depth
	assign wr_idx    = rd_ptr + count[PTR_W-1:0];
	assign full      = (count == (PTR_W+1)'(`ACQ_HDR_DEPTH));
	assign hdr_empty = (count == '0);
	assign push      = bus.hdr_wr && !full;
	assign pop       = hdr_rd && !hdr_empty;

	always_ff @(posedge clk) begin
		if (push)
			fifo_mem[wr_idx] <= hdr_q.raw;
	end

	always_ff @(posedge clk) begin
		if (rst_sync1) begin
			rd_ptr       <= '0;
			count        <= '0;
			hdr_overflow <= 1'b0;
		end else begin
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			// Sticky until reset, the dropped word is lost
			if (bus.hdr_wr && full)
				hdr_overflow <= 1'b1;
		end
	end

	// Head word shows without a read latency
	assign hdr_rd_data = fifo_mem[rd_ptr];

	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_sync1) hdr_rd |-> !hdr_empty)
		else $error("header FIFO read while empty");
	a_hdr_overflow: assert property (@(posedge clk) disable iff (rst_sync1) bus.hdr_wr |-> !full)
		else $warning("header FIFO full, header word dropped");

endmodule

`default_nettype wire

// ==== source/acq_sample_mem.sv ====
//////////////////////////////////////////////////
// Sample buffer, written by the acquisition and read from outside
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps
`include "acq_cfg.svh"

module acq_sample_mem (
	input  wire                    clk,
	input  wire                    wr_en,
	input  wire [`ACQ_ADDR_W-1:0]  wr_addr,
	input  wire [`ACQ_WORD_W-1:0]  wr_data,
	input  wire [`ACQ_ADDR_W-1:0]  rd_addr,
	output logic [`ACQ_WORD_W-1:0] rd_data
);

	// One word per address, the full address range is used
	localparam int DEPTH = 1 << `ACQ_ADDR_W;

	logic [`ACQ_WORD_W-1:0] mem [DEPTH];

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////
	// One ADC word per enabled cycle
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	//////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////
	// Registered output so the array maps onto block RAM
	// Data appears one cycle after the address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== source/adc_acq_top.sv ====
//////////////////////////////////////////////////
// Acquisition front end for one ADC channel
// Register values come in as plain ports and stay stable while armed
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps
`include "acq_cfg.svh"

module adc_acq_top (
	input  wire                    clk,
	input  wire                    rst_sync1,
	input  wire                    arm,
	input  wire                    trig,
	input  wire                    trig_num_we,
	input  wire [`ACQ_WORD_W-1:0]  adc_data,
	input  wire [`ACQ_WORD_W-1:0]  buffer_size,
	input  wire [`ACQ_WORD_W-1:0]  channel_num,
	input  wire [`ACQ_WORD_W-1:0]  post_trig_size,
	input  wire [`ACQ_WORD_W-1:0]  initial_trig_num,
	input  wire [`ACQ_ADDR_W-1:0]  mem_rd_addr,
	input  wire                    hdr_rd,
	output logic                   done,
	output logic [`ACQ_WORD_W-1:0] current_trig_num,
	output logic [`ACQ_WORD_W-1:0] mem_rd_data,
	output logic [`ACQ_WORD_W-1:0] hdr_rd_data,
	output logic                   hdr_empty,
	output logic                   hdr_overflow
);

	// Strobes from the FSM and the write address back from the address generator
	acq_ctrl_if ctrl_bus ();

	acq_control acq_control_inst (
		.clk         (clk),
		.rst_sync1   (rst_sync1),
		.arm         (arm),
		.trig        (trig),
		.trig_num_we (trig_num_we),
		.done        (done),
		.bus         (ctrl_bus.ctrl)
	);

	// Only the low address bits of the sizes matter to the counters
	acq_addr_gen acq_addr_gen_inst (
		.clk            (clk),
		.rst_sync1      (rst_sync1),
		.post_trig_size (post_trig_size[`ACQ_ADDR_W-1:0]),
		.buffer_size    (buffer_size[`ACQ_ADDR_W-1:0]),
		.bus            (ctrl_bus.addr)
	);

	acq_header_fifo acq_header_fifo_inst (
		.clk              (clk),
		.rst_sync1        (rst_sync1),
		.buffer_size      (buffer_size),
		.channel_num      (channel_num),
		.post_trig_size   (post_trig_size),
		.initial_trig_num (initial_trig_num),
		.hdr_rd           (hdr_rd),
		.current_trig_num (current_trig_num),
		.hdr_rd_data      (hdr_rd_data),
		.hdr_empty        (hdr_empty),
		.hdr_overflow     (hdr_overflow),
		.bus              (ctrl_bus.hdr)
	);

	acq_sample_mem acq_sample_mem_inst (
		.clk     (clk),
		.wr_en   (ctrl_bus.wr_en),
		.wr_addr (ctrl_bus.wr_addr),
		.wr_data (adc_data),
		.rd_addr (mem_rd_addr),
		.rd_data (mem_rd_data)
	);

endmodule

`default_nettype wire

// ==== verif/adc_acq_tb.sv ====
//////////////////////////////////////////////////
// Testbench for the ADC acquisition front end
// Runs random events, then checks headers, trigger numbers and sample data
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "acq_cfg.svh"

module adc_acq_tb;
	import acq_pkg::*;

	// Each event needs its pre-trigger wait, its post-trigger run and up to
	// two readout cycles per buffered word, plus fixed overhead
	localparam int N_EVENTS     = 10;
	localparam int MAX_GAP      = 35;
	localparam int MAX_POST     = 64;
	localparam int EVENT_CYCLES = MAX_GAP + 3 * MAX_POST + 60;
	localparam int LIMIT        = N_EVENTS * EVENT_CYCLES + 400;

	logic                   clk;
	logic                   rst_sync1;
	logic                   arm;
	logic                   trig;
	logic                   trig_num_we;
	logic [`ACQ_WORD_W-1:0] adc_data = '0;
	logic [`ACQ_WORD_W-1:0] buffer_size;
	logic [`ACQ_WORD_W-1:0] channel_num;
	logic [`ACQ_WORD_W-1:0] post_trig_size;
	logic [`ACQ_WORD_W-1:0] initial_trig_num;
	logic [`ACQ_ADDR_W-1:0] mem_rd_addr;
	logic                   hdr_rd;
	logic                   done;
	logic [`ACQ_WORD_W-1:0] current_trig_num;
	logic [`ACQ_WORD_W-1:0] mem_rd_data;
	logic [`ACQ_WORD_W-1:0] hdr_rd_data;
	logic                   hdr_empty;
	logic                   hdr_overflow;

	logic [31:0]            rng = 32'h93fa_d33c;
	logic [31:0]            exp_trig;
	logic [31:0]            exp_q [$];
	logic [31:0]            last_word;
	hdr_word_u              start_word;
	int                     cycles = 0;
	int                     ev;

	adc_acq_top adc_acq_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Free-running sample counter, so stored data must come out consecutive
	always @(posedge clk) begin
		adc_data <= adc_data + 32'd1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout after %0d cycles, the acquisition never finished", cycles);
			$display("test failed");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Draws a value in lo .. lo+span-1
	task automatic pick_range(input int lo, input int span, output int val);
		rng = xorshift32(rng);
		val = lo + int'(rng % 32'(span));
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// Samples the head word mid-cycle, then pops it with a one-cycle strobe
	task automatic read_header_word(output logic [31:0] word);
		@(negedge clk);
		check_value("hdr_available", 32'd0, 32'(hdr_empty));
		word = hdr_rd_data;
		@(posedge clk) hdr_rd <= 1'b1;
		@(posedge clk) hdr_rd <= 1'b0;
	endtask

	task automatic read_and_compare(input int n, input string name);
		logic [31:0] word;
		logic [31:0] expected;
		int          i;
		for (i = 0; i < n; i++) begin
			read_header_word(word);
			expected = exp_q.pop_front();
			check_value(name, expected, word);
			last_word = word;
		end
	endtask

	// Buffered words must follow each other with no gap, read with wrap
	task automatic check_window(input logic [`ACQ_ADDR_W-1:0] start, input int count);
		logic [31:0] first;
		logic [31:0] word;
		int          i;
		first = '0;
		for (i = 0; i < count; i++) begin
			@(posedge clk) mem_rd_addr <= start + `ACQ_ADDR_W'(i);
			@(posedge clk);
			@(negedge clk) word = mem_rd_data;
			if (i == 0)
				first = word;
			else
				check_value("sample_window", first + 32'(i), word);
		end
	endtask

	// One acquisition with random sizes, ending once done is seen
	task automatic start_event();
		int                     gap;
		int                     pts;
		int                     bs;
		logic [`ACQ_ADDR_W-1:0] start;
		pick_range(4, MAX_GAP - 3, gap);
		pick_range(1, MAX_POST, pts);
		pick_range(1, pts, bs);
		rng = xorshift32(rng);
		@(posedge clk);
		post_trig_size <= 32'(pts);
		buffer_size    <= 32'(bs);
		channel_num    <= rng;
		@(posedge clk) arm <= 1'b1;
		repeat (gap) @(posedge clk);
		trig <= 1'b1;
		@(posedge clk) trig <= 1'b0;
		// Arm reaches INIT after 3 cycles and trig needs 3 more to leave WAIT_TRIG,
		// so gap + pts words are recorded and the window ends at that address
		start = `ACQ_ADDR_W'(gap + pts - bs);
		exp_q.push_back(exp_trig);
		exp_q.push_back(32'(bs));
		exp_q.push_back(rng);
		exp_q.push_back(32'(pts));
		exp_q.push_back({{(`ACQ_WORD_W-`ACQ_ADDR_W){1'b0}}, start});
		do @(negedge clk); while (done !== 1'b1);
		check_value("trig_num_next", exp_trig + 32'd1, current_trig_num);
		exp_trig = exp_trig + 32'd1;
	endtask

	task automatic disarm();
		@(posedge clk) arm <= 1'b0;
		do @(negedge clk); while (done !== 1'b0);
		repeat (2) @(posedge clk);
	endtask

	//////////////////////////////////////////////////
	// Concurrent checks
	//////////////////////////////////////////////////
	done_level: assert property (@(posedge clk) disable iff (rst_sync1) done && arm |=> done)
		else begin
			$display("FAIL done_level expected 1 actual %0b", done);
			$display("test failed");
			$fatal(1);
		end

	// Two sync flops plus the state register clear done four samples after arm drops
	idle_done: assert property (@(posedge clk) disable iff (rst_sync1)
		!arm && !$past(arm) && !$past(arm, 2) && !$past(arm, 3) |-> !done)
		else begin
			$display("FAIL idle_done expected 0 actual %0b", done);
			$display("test failed");
			$fatal(1);
		end

	idle_no_header: assert property (@(posedge clk) disable iff (rst_sync1)
		!arm && !$past(arm) && !$past(arm, 2) && !$past(arm, 3) && !$past(arm, 4)
		|-> !$fell(hdr_empty))
		else begin
			$display("FAIL idle_no_header expected 1 actual %0b", hdr_empty);
			$display("test failed");
			$fatal(1);
		end

	overflow_sticky: assert property (@(posedge clk) disable iff (rst_sync1)
		hdr_overflow |=> hdr_overflow)
		else begin
			$display("FAIL overflow_sticky expected 1 actual %0b", hdr_overflow);
			$display("test failed");
			$fatal(1);
		end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin
		rst_sync1        = 1'b1;
		arm              = 1'b0;
		trig             = 1'b0;
		trig_num_we      = 1'b0;
		buffer_size      = '0;
		channel_num      = '0;
		post_trig_size   = '0;
		initial_trig_num = '0;
		mem_rd_addr      = '0;
		hdr_rd           = 1'b0;
		repeat (8) @(posedge clk);
		rst_sync1 <= 1'b0;

		// Idle outputs, and a trigger while unarmed leaves the FIFO empty
		@(negedge clk);
		check_value("reset_done", 32'd0, 32'(done));
		check_value("reset_empty", 32'd1, 32'(hdr_empty));
		check_value("reset_overflow", 32'd0, 32'(hdr_overflow));
		@(posedge clk) trig <= 1'b1;
		@(posedge clk) trig <= 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk) check_value("unarmed_trig", 32'd1, 32'(hdr_empty));

		// Load the trigger number through its synchronized write strobe
		rng = xorshift32(rng);
		exp_trig = rng;
		@(posedge clk);
		initial_trig_num <= rng;
		trig_num_we      <= 1'b1;
		@(posedge clk) trig_num_we <= 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk) check_value("trig_num_load", exp_trig, current_trig_num);

		// Full check of every event, with readout while still armed
		for (ev = 0; ev < 3; ev++) begin
			start_event();
			repeat (4) @(posedge clk);
			@(negedge clk) check_value("done_hold", 32'd1, 32'(done));
			read_and_compare(`ACQ_HDR_WORDS, "header_word");
			start_word.raw = last_word;
			@(negedge clk) check_value("header_count", 32'd1, 32'(hdr_empty));
			check_window(start_word.adr.start_adr, int'(buffer_size));
			disarm();
		end

		// Three events fill 15 of 16 entries, read back in order
		for (ev = 0; ev < 3; ev++) begin
			start_event();
			disarm();
		end
		check_value("no_overflow", 32'd0, 32'(hdr_overflow));
		read_and_compare(3 * `ACQ_HDR_WORDS, "fifo_order");
		@(negedge clk) check_value("fifo_drained", 32'd1, 32'(hdr_empty));

		// Four events give 20 words, so the last four are dropped
		for (ev = 0; ev < 4; ev++) begin
			start_event();
			disarm();
		end
		check_value("overflow_set", 32'd1, 32'(hdr_overflow));
		read_and_compare(`ACQ_HDR_DEPTH, "fifo_full");
		@(negedge clk) check_value("full_drained", 32'd1, 32'(hdr_empty));
		exp_q.delete();

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+source
source/acq_pkg.sv
source/acq_ctrl_if.sv
source/acq_control.sv
source/acq_addr_gen.sv
source/acq_header_fifo.sv
source/acq_sample_mem.sv
source/adc_acq_top.sv
verif/adc_acq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the ADC acquisition testbench with Verilator and run it.
# The exit status is nonzero unless the simulation log shows a pass.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module adc_acq_tb \
	-o adc_acq_sim > build.log 2>&1 || { cat build.log; echo "BUILD FAILED"; exit 1; }

./obj_dir/adc_acq_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log

grep -qx "test passed" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }
